//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_spu_top -f all.f --Mdir obj_dir
	./obj_dir/Vtb_spu_top | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+hw
+incdir+sim
hw/spu_pkg.sv
hw/spu_op_if.sv
hw/spu_delay.sv
hw/spu_src_stage.sv
hw/spu_op_logic.sv
hw/spu_top.sv
sim/tb_spu_top.sv

//--- hw/spu_defs.svh
`ifndef SPU_DEFS_SVH
`define SPU_DEFS_SVH

// ------------------------------
// datapath sizing
// ------------------------------

`define SPU_DATA_BITS   16                          // bits per data word

// enabled cycles from the logic unit operand register to m_data, at least 1
`define SPU_LATENCY     2

`define SPU_CLEAR_DATA  ({`SPU_DATA_BITS{1'b1}})    // result value on clear

`endif

//--- hw/spu_delay.sv
`timescale 1ns/10ps
`default_nettype none

// shift register that only advances on enabled cycles
module spu_delay #(
    parameter type t     = logic,   // payload type
    parameter int  DEPTH = 1        // number of stages, 0 passes through
) (
    input  logic clk,
    input  logic reset,
    input  logic cke,
    input  t     din,
    output t     dout
);

    generate
        if (DEPTH == 0) begin : g_pass
            assign dout = din;                  // no stages requested
        end else begin : g_shift
            t stage [DEPTH];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage[i] <= '0;
                    end
                end else if (cke) begin
                    stage[0] <= din;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage[i] <= stage[i-1]; // move one stage along
                    end
                end
            end

            assign dout = stage[DEPTH-1];
        end
    endgenerate

endmodule

`default_nettype wire

//--- hw/spu_op_if.sv
`timescale 1ns/10ps
`default_nettype none

// registered operands and control, source stage to logic unit
// one transfer per rising edge with cke high, valid qualifies the data
interface spu_op_if;

    spu_pkg::data_t   data0;    // operand 0
    spu_pkg::data_t   data1;    // operand 1, immediate already applied
    spu_pkg::opcode_t opcode;   // operation select
    logic             clear;    // load clear value into result
    logic             valid;    // operands are meaningful

    // source stage side
    modport src (
        output data0,
        output data1,
        output opcode,
        output clear,
        output valid
    );

    // logic unit side
    modport op (
        input  data0,
        input  data1,
        input  opcode,
        input  clear,
        input  valid
    );

endinterface

`default_nettype wire

//--- hw/spu_op_logic.sv
`timescale 1ns/10ps
`default_nettype none

`include "spu_defs.svh"

// bitwise operation, clear/hold result register and output delay
module spu_op_logic (
    input  logic           clk,
    input  logic           reset,
    input  logic           cke,

    spu_op_if.op           op_in,

    output spu_pkg::data_t m_data,
    output logic           m_valid
);

    // ------------------------------
    // operation select
    // ------------------------------

    spu_pkg::data_t op_result;

    always_comb begin
        case (op_in.opcode)
            spu_pkg::OP_OR:   op_result = op_in.data0 | op_in.data1;
            spu_pkg::OP_AND:  op_result = op_in.data0 & op_in.data1;
            spu_pkg::OP_XOR:  op_result = op_in.data0 ^ op_in.data1;
            spu_pkg::OP_ANDN: op_result = op_in.data0 & ~op_in.data1;
            default:          op_result = op_in.data0 | op_in.data1;
        endcase
    end

    // ------------------------------
    // result register
    // ------------------------------

    spu_pkg::data_t result_data;
    logic           result_upd;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_data <= '0;
            result_upd  <= 1'b0;
        end else if (cke) begin
            if (op_in.clear) begin
                result_data <= `SPU_CLEAR_DATA;     // clear wins over valid
            end else if (op_in.valid) begin
                result_data <= op_result;
            end
            result_upd <= op_in.clear | op_in.valid; // register was loaded
        end
    end

    // remaining latency with the flag kept in step with the data
    spu_delay #(
        .t     (spu_pkg::data_t),
        .DEPTH (`SPU_LATENCY - 1)
    ) i_delay_data (
        .clk   (clk),
        .reset (reset),
        .cke   (cke),
        .din   (result_data),
        .dout  (m_data)
    );

    spu_delay #(
        .t     (logic),
        .DEPTH (`SPU_LATENCY - 1)
    ) i_delay_valid (
        .clk   (clk),
        .reset (reset),
        .cke   (cke),
        .din   (result_upd),
        .dout  (m_valid)
    );

endmodule

`default_nettype wire

//--- hw/spu_pkg.sv
`default_nettype none

package spu_pkg;

    `include "spu_defs.svh"

    // ------------------------------
    // payload types
    // ------------------------------

    typedef logic [`SPU_DATA_BITS-1:0] data_t;  // one data word

    // bitwise operation select
    typedef enum logic [1:0] {
        OP_OR   = 2'd0,                         // data0 | data1
        OP_AND  = 2'd1,                         // data0 & data1
        OP_XOR  = 2'd2,                         // data0 ^ data1
        OP_ANDN = 2'd3                          // data0 & ~data1
    } opcode_t;

endpackage

`default_nettype wire

//--- hw/spu_src_stage.sv
`timescale 1ns/10ps
`default_nettype none

// immediate register, operand 1 select and input register stage
module spu_src_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             cke,

    input  spu_pkg::data_t   s_data0,
    input  spu_pkg::data_t   s_data1,
    input  spu_pkg::opcode_t s_opcode,
    input  logic             s_use_imm,
    input  logic             s_clear,
    input  logic             s_valid,

    input  logic             imm_load,
    input  spu_pkg::data_t   imm_data,

    spu_op_if.src            op_out
);

    // ------------------------------
    // immediate register
    // ------------------------------

    spu_pkg::data_t imm_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            imm_reg <= '0;
        end else if (cke && imm_load) begin
            imm_reg <= imm_data;                // visible from next enabled cycle
        end
    end

    // ------------------------------
    // operand 1 select
    // ------------------------------

    spu_pkg::data_t data1_sel;

    always_comb begin
        if (s_use_imm) begin
            data1_sel = imm_reg;
        end else begin
            data1_sel = s_data1;
        end
    end

    // ------------------------------
    // input register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            op_out.data0  <= '0;
            op_out.data1  <= '0;
            op_out.opcode <= spu_pkg::OP_OR;
            op_out.clear  <= 1'b0;
            op_out.valid  <= 1'b0;
        end else if (cke) begin
            op_out.data0  <= s_data0;
            op_out.data1  <= data1_sel;
            op_out.opcode <= s_opcode;
            op_out.clear  <= s_clear;
            op_out.valid  <= s_valid;
        end
    end

endmodule

`default_nettype wire

//--- hw/spu_top.sv
`timescale 1ns/10ps
`default_nettype none

// scalar processing unit, one bitwise logic slice
// inputs reach m_data after SPU_LATENCY+1 enabled edges
module spu_top (
    input  logic             clk,
    input  logic             reset,         // synchronous, active high
    input  logic             cke,           // stalls the whole pipeline

    // ------------------------------
    // operand input
    // ------------------------------

    input  spu_pkg::data_t   s_data0,
    input  spu_pkg::data_t   s_data1,
    input  spu_pkg::opcode_t s_opcode,
    input  logic             s_use_imm,     // take immediate for operand 1
    input  logic             s_clear,
    input  logic             s_valid,

    // ------------------------------
    // immediate load
    // ------------------------------

    input  logic             imm_load,
    input  spu_pkg::data_t   imm_data,

    // ------------------------------
    // result output
    // ------------------------------

    output spu_pkg::data_t   m_data,
    output logic             m_valid        // m_data was updated
);

    spu_op_if op_bus ();                    // source stage to logic unit

    spu_src_stage i_src_stage (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),

        .s_data0   (s_data0),
        .s_data1   (s_data1),
        .s_opcode  (s_opcode),
        .s_use_imm (s_use_imm),
        .s_clear   (s_clear),
        .s_valid   (s_valid),

        .imm_load  (imm_load),
        .imm_data  (imm_data),

        .op_out    (op_bus.src)
    );

    spu_op_logic i_op_logic (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),

        .op_in     (op_bus.op),

        .m_data    (m_data),
        .m_valid   (m_valid)
    );

endmodule

`default_nettype wire

//--- sim/tb_spu_model.svh
// ------------------------------
// reference model
// ------------------------------

// expected value of one bitwise operation, worked out bit by bit
function automatic spu_pkg::data_t spu_model_op(
    input spu_pkg::opcode_t op,
    input spu_pkg::data_t   a,
    input spu_pkg::data_t   b
);
    spu_pkg::data_t r;
    r = '0;
    for (int i = 0; i < `SPU_DATA_BITS; i++) begin
        case (op)
            spu_pkg::OP_OR:   r[i] = a[i] | b[i];
            spu_pkg::OP_AND:  r[i] = a[i] & b[i];
            spu_pkg::OP_XOR:  r[i] = (a[i] != b[i]);    // differ means one
            spu_pkg::OP_ANDN: r[i] = a[i] & !b[i];      // data0 and not data1
            default:          r[i] = 1'b0;
        endcase
    end
    return r;
endfunction

// ------------------------------
// compare tasks
// ------------------------------

task automatic check_data(
    input string          name,
    input spu_pkg::data_t actual,
    input spu_pkg::data_t expected
);
    if (actual !== expected) begin
        $display("Error at %0t: %s is 'h%h, expected 'h%h", $time, name, actual, expected);
        error_count++;
    end
endtask

task automatic check_valid(
    input string name,
    input logic  actual,
    input logic  expected
);
    if (actual !== expected) begin
        $display("Error at %0t: %s is %b, expected %b", $time, name, actual, expected);
        error_count++;
    end
endtask

//--- sim/tb_spu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "spu_defs.svh"

module tb_spu_top;

    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = `SPU_LATENCY + 2;
    localparam int EXH_CYCLES   = 3 * 3 * 4 * 4;   // d0 pattern, d1 pattern, opcode, clear/valid
    localparam int HOLD_CYCLES  = 40;
    localparam int IMM_CYCLES   = 50;
    localparam int LAT_CYCLES   = 20;
    localparam int RAND_CYCLES  = 400;
    localparam int MRST_CYCLES  = 60;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + EXH_CYCLES + HOLD_CYCLES + IMM_CYCLES
                                + LAT_CYCLES + RAND_CYCLES + MRST_CYCLES
                                + 6 * DRAIN_CYCLES + 200;

    logic             clk;
    logic             reset;
    logic             cke;
    spu_pkg::data_t   s_data0;
    spu_pkg::data_t   s_data1;
    spu_pkg::opcode_t s_opcode;
    logic             s_use_imm;
    logic             s_clear;
    logic             s_valid;
    logic             imm_load;
    spu_pkg::data_t   imm_data;
    spu_pkg::data_t   m_data;
    logic             m_valid;

    int error_count;
    int test_count;
    int failed_tests;
    int cycle_count;
    bit check_on;

    `include "tb_spu_model.svh"

    spu_top i_spu_top (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .s_data0   (s_data0),
        .s_data1   (s_data1),
        .s_opcode  (s_opcode),
        .s_use_imm (s_use_imm),
        .s_clear   (s_clear),
        .s_valid   (s_valid),
        .imm_load  (imm_load),
        .imm_data  (imm_data),
        .m_data    (m_data),
        .m_valid   (m_valid)
    );

    always #10 clk = ~clk;                      // 20 ns period

    // ------------------------------
    // model pipeline
    // ------------------------------

    spu_pkg::data_t   mdl_imm;
    spu_pkg::data_t   mdl_d0;
    spu_pkg::data_t   mdl_d1;
    spu_pkg::opcode_t mdl_op;
    logic             mdl_clear;
    logic             mdl_valid;
    spu_pkg::data_t   mdl_res [`SPU_LATENCY];   // result register, then delay stages
    logic             mdl_upd [`SPU_LATENCY];

    always @(posedge clk) begin
        if (reset) begin
            mdl_imm   <= '0;
            mdl_d0    <= '0;
            mdl_d1    <= '0;
            mdl_op    <= spu_pkg::OP_OR;
            mdl_clear <= 1'b0;
            mdl_valid <= 1'b0;
            for (int i = 0; i < `SPU_LATENCY; i++) begin
                mdl_res[i] <= '0;
                mdl_upd[i] <= 1'b0;
            end
        end else if (cke) begin                 // only enabled edges count
            if (imm_load) begin
                mdl_imm <= imm_data;
            end
            mdl_d0    <= s_data0;
            mdl_d1    <= s_use_imm ? mdl_imm : s_data1;
            mdl_op    <= s_opcode;
            mdl_clear <= s_clear;
            mdl_valid <= s_valid;
            if (mdl_clear) begin
                mdl_res[0] <= `SPU_CLEAR_DATA;
            end else if (mdl_valid) begin
                mdl_res[0] <= spu_model_op(mdl_op, mdl_d0, mdl_d1);
            end
            mdl_upd[0] <= mdl_clear | mdl_valid;
            for (int i = 1; i < `SPU_LATENCY; i++) begin
                mdl_res[i] <= mdl_res[i-1];
                mdl_upd[i] <= mdl_upd[i-1];
            end
        end
    end

    // compares values settled by the previous edge
    always @(posedge clk) begin
        if (check_on) begin
            check_data("m_data", m_data, mdl_res[`SPU_LATENCY-1]);
            check_valid("m_valid", m_valid, mdl_upd[`SPU_LATENCY-1]);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------
    // stimulus helpers
    // ------------------------------

    function automatic spu_pkg::data_t operand_pattern(input int pat);
        if (pat == 0) begin
            return '0;
        end else if (pat == 1) begin
            return '1;
        end
        return spu_pkg::data_t'($urandom);
    endfunction

    task automatic drive_idle();
        s_data0   = '0;
        s_data1   = '0;
        s_opcode  = spu_pkg::OP_OR;
        s_use_imm = 1'b0;
        s_clear   = 1'b0;
        s_valid   = 1'b0;
        imm_load  = 1'b0;
        imm_data  = '0;
    endtask

    task automatic drive_random_item(input logic allow_load);
        s_data0   = spu_pkg::data_t'($urandom);
        s_data1   = spu_pkg::data_t'($urandom);
        s_opcode  = spu_pkg::opcode_t'(2'($urandom_range(3)));
        s_use_imm = ($urandom_range(1) == 1);
        s_valid   = ($urandom_range(1) == 1);
        s_clear   = ($urandom_range(7) == 0);   // clear now and then
        imm_load  = allow_load && ($urandom_range(7) == 0);
        imm_data  = spu_pkg::data_t'($urandom);
    endtask

    task automatic drive_op(
        input spu_pkg::opcode_t op,
        input spu_pkg::data_t   d0,
        input spu_pkg::data_t   d1,
        input logic             use_imm
    );
        drive_idle();
        s_opcode  = op;
        s_data0   = d0;
        s_data1   = d1;
        s_use_imm = use_imm;
        s_valid   = 1'b1;
    endtask

    task automatic drain_pipeline();
        drive_idle();
        cke = 1'b1;
        repeat (DRAIN_CYCLES) @(negedge clk);
    endtask

    task automatic report_test(input string name, input int start_errors);
        int n;
        n = error_count - start_errors;
        test_count++;
        if (n == 0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, n);
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------

    task automatic run_exhaustive();
        int start;
        start = error_count;
        for (int n = 0; n < EXH_CYCLES; n++) begin
            drive_idle();
            s_data0  = operand_pattern(n % 3);
            s_data1  = operand_pattern((n / 3) % 3);
            s_opcode = spu_pkg::opcode_t'(2'((n / 9) % 4));
            {s_clear, s_valid} = 2'((n / 36) % 4);
            @(negedge clk);
        end
        drain_pipeline();
        report_test("exhaustive opcodes", start);
    endtask

    task automatic run_hold_clear();
        int start;
        start = error_count;
        repeat (8) begin
            drive_op(spu_pkg::opcode_t'(2'($urandom_range(3))), spu_pkg::data_t'($urandom),
                     spu_pkg::data_t'($urandom), 1'b0);
            @(negedge clk);
        end
        drive_idle();
        repeat (6) @(negedge clk);              // result must hold
        drive_random_item(1'b0);
        s_clear = 1'b1;
        s_valid = 1'b1;
        @(negedge clk);
        drive_idle();
        repeat (6) @(negedge clk);
        drive_op(spu_pkg::OP_AND, spu_pkg::data_t'($urandom), spu_pkg::data_t'($urandom), 1'b0);
        @(negedge clk);
        drive_random_item(1'b0);
        s_clear = 1'b1;                         // clear without valid
        s_valid = 1'b0;
        @(negedge clk);
        drain_pipeline();
        check_data("m_data", m_data, `SPU_CLEAR_DATA);
        check_valid("m_valid", m_valid, 1'b0);
        report_test("hold and clear", start);
    endtask

    task automatic run_immediate();
        int             start;
        spu_pkg::data_t imm_b;
        start = error_count;
        drive_op(spu_pkg::OP_XOR, spu_pkg::data_t'($urandom), spu_pkg::data_t'($urandom), 1'b0);
        imm_load = 1'b1;
        imm_data = spu_pkg::data_t'($urandom);
        @(negedge clk);
        repeat (10) begin
            drive_random_item(1'b0);
            s_use_imm = 1'b1;
            @(negedge clk);
        end
        imm_b = spu_pkg::data_t'($urandom);
        drive_random_item(1'b0);
        s_use_imm = 1'b1;                       // still sees the old immediate
        imm_load  = 1'b1;
        imm_data  = imm_b;
        @(negedge clk);
        repeat (10) begin
            drive_random_item(1'b0);
            s_use_imm = 1'b1;
            @(negedge clk);
        end
        repeat (10) begin
            drive_random_item(1'b0);
            s_use_imm = 1'b0;
            @(negedge clk);
        end
        drive_op(spu_pkg::OP_OR, '0, spu_pkg::data_t'($urandom), 1'b1);
        @(negedge clk);
        drain_pipeline();
        check_data("m_data", m_data, imm_b);
        report_test("immediate operand", start);
    endtask

    task automatic run_latency();
        int             start;
        int             enabled;
        spu_pkg::data_t d0;
        spu_pkg::data_t d1;
        start = error_count;
        drain_pipeline();
        d0 = spu_pkg::data_t'($urandom);
        d1 = spu_pkg::data_t'($urandom);
        drive_op(spu_pkg::OP_ANDN, d0, d1, 1'b0);
        @(negedge clk);                         // sampling edge has passed
        drive_idle();
        enabled = 1;
        while (!m_valid && enabled < `SPU_LATENCY + 4) begin
            @(negedge clk);
            enabled++;
        end
        if (enabled != `SPU_LATENCY + 1) begin
            $display("latency: m_valid came after %0d enabled edges instead of %0d",
                     enabled, `SPU_LATENCY + 1);
            error_count++;
        end
        check_data("m_data", m_data, spu_model_op(spu_pkg::OP_ANDN, d0, d1));
        drain_pipeline();
        report_test("latency", start);
    endtask

    task automatic run_random_stall();
        int start;
        start = error_count;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            drive_random_item(1'b1);
            cke = ($urandom_range(9) != 0);     // stall about one cycle in ten
            @(negedge clk);
        end
        drain_pipeline();
        report_test("random with stalls", start);
    endtask

    task automatic run_mid_reset();
        int start;
        start = error_count;
        drive_random_item(1'b0);
        imm_load = 1'b1;
        imm_data = spu_pkg::data_t'($urandom_range(16'hffff, 1));  // never zero
        @(negedge clk);
        repeat (20) begin
            drive_random_item(1'b0);
            @(negedge clk);
        end
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        check_data("m_data", m_data, '0);
        check_valid("m_valid", m_valid, 1'b0);
        repeat (20) begin
            drive_random_item(1'b0);
            s_use_imm = 1'b1;
            @(negedge clk);
        end
        drive_op(spu_pkg::OP_OR, '0, spu_pkg::data_t'($urandom), 1'b1);
        @(negedge clk);
        drain_pipeline();
        check_data("m_data", m_data, '0);       // immediate was cleared
        report_test("reset mid-stream", start);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        void'($urandom(56));
        clk          = 1'b0;
        reset        = 1'b1;
        cke          = 1'b1;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        cycle_count  = 0;
        check_on     = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(negedge clk);
        reset    = 1'b0;
        check_on = 1'b1;

        run_exhaustive();
        run_hold_clear();
        run_immediate();
        run_latency();
        run_random_stall();
        run_mid_reset();

        $display("tests: %0d  failed: %0d  errors: %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
